//--- rtl/axi_ax_pkg.sv
// AXI address channel definitions
// Field widths and fixed encodings used on AW and AR
package axi_ax_pkg;

  // ========================================
  // Field widths
  // ========================================

  localparam int unsigned AX_LEN_W   = 8;
  localparam int unsigned AX_SIZE_W  = 3;
  localparam int unsigned AX_BURST_W = 2;
  localparam int unsigned AX_CACHE_W = 4;

  // ========================================
  // Encodings
  // ========================================

  // Log2 of the 8 byte bus width
  localparam logic [AX_SIZE_W-1:0]  AX_SIZE_BUS      = 3'd3;

  // Incrementing burst
  localparam logic [AX_BURST_W-1:0] BURST_INCR       = 2'b01;

  // Normal non-cacheable, modifiable
  localparam logic [AX_CACHE_W-1:0] CACHE_MODIFIABLE = 4'b0010;

endpackage

//--- rtl/vlsu_ax_issue.sv
// AXI address issue stage
// One entry register that forms an AW or AR request and holds it
// until the selected channel accepts it
module vlsu_ax_issue import vlsu_txn_pkg::*; import axi_ax_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Entry from the queue
  input  logic                  ax_valid_i,
  output logic                  ax_ready_o,
  input  txn_ctrl_t             ax_entry_i,
  // Write address
  output logic                  aw_valid_o,
  input  logic                  aw_ready_i,
  output logic [ADDR_W-1:0]     aw_addr_o,
  output logic [AX_LEN_W-1:0]   aw_len_o,
  output logic [AX_SIZE_W-1:0]  aw_size_o,
  output logic [AX_BURST_W-1:0] aw_burst_o,
  output logic [AX_CACHE_W-1:0] aw_cache_o,
  // Read address
  output logic                  ar_valid_o,
  input  logic                  ar_ready_i,
  output logic [ADDR_W-1:0]     ar_addr_o,
  output logic [AX_LEN_W-1:0]   ar_len_o,
  output logic [AX_SIZE_W-1:0]  ar_size_o,
  output logic [AX_BURST_W-1:0] ar_burst_o,
  output logic [AX_CACHE_W-1:0] ar_cache_o
);

  logic      valid_q;
  txn_ctrl_t entry_q;
  logic      accepted;

  // Slave takes the held request
  assign accepted   = (aw_valid_o && aw_ready_i) || (ar_valid_o && ar_ready_i);
  // Free, or freed in this cycle
  assign ax_ready_o = !valid_q || accepted;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (ax_valid_i && ax_ready_o) begin
      valid_q <= 1'b1;
    end else if (accepted) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ax_valid_i && ax_ready_o) begin
      entry_q <= ax_entry_i;
    end
  end

  // ========================================
  // Channel routing
  // ========================================
  assign aw_valid_o = valid_q && !entry_q.is_load;
  assign ar_valid_o = valid_q && entry_q.is_load;

  // Address goes out unchanged
  assign aw_addr_o  = entry_q.addr;
  assign aw_len_o   = AX_LEN_W'(entry_q.rmn_beat);
  assign aw_size_o  = AX_SIZE_BUS;
  assign aw_burst_o = BURST_INCR;
  assign aw_cache_o = CACHE_MODIFIABLE;

  assign ar_addr_o  = entry_q.addr;
  assign ar_len_o   = AX_LEN_W'(entry_q.rmn_beat);
  assign ar_size_o  = AX_SIZE_BUS;
  assign ar_burst_o = BURST_INCR;
  assign ar_cache_o = CACHE_MODIFIABLE;

endmodule

//--- rtl/vlsu_circ_ptr.sv
// Circular queue pointer
// Index wraps at the queue depth and toggles a flag on each wrap,
// so equal indices can be told apart as full or empty
module vlsu_circ_ptr import vlsu_txn_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 inc_i,
  output logic                 flag_o,
  output logic [TXN_PTR_W-1:0] value_o
);

  logic                 flag_q;
  logic [TXN_PTR_W-1:0] value_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flag_q  <= 1'b0;
      value_q <= '0;
    end else if (inc_i) begin
      if (value_q == TXN_PTR_W'(TXN_CTRL_NUM - 1)) begin
        // Wrap around, next lap
        value_q <= '0;
        flag_q  <= ~flag_q;
      end else begin
        value_q <= value_q + 1'b1;
      end
    end
  end

  assign flag_o  = flag_q;
  assign value_o = value_q;

endmodule

//--- rtl/vlsu_meta_seq.sv
// Vector load/store meta sequencer
// Expands one request into per-transaction metadata words,
// walking groups, then segments, then transactions
module vlsu_meta_seq import vlsu_txn_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Request, counts are nonzero
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  logic              req_is_load_i,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  logic [CNT_W-1:0]  req_nr_grp_i,
  input  logic [CNT_W-1:0]  req_nr_seg_i,
  input  logic [CNT_W-1:0]  req_nr_txn_i,
  input  logic [BEAT_W-1:0] req_len_i,
  // Metadata stream
  output logic              meta_valid_o,
  input  logic              meta_ready_i,
  output logic [ADDR_W-1:0] meta_addr_o,
  output logic [BEAT_W-1:0] meta_len_o,
  output logic              meta_is_load_o,
  output logic              meta_is_final_o
);

  // Control state
  logic             busy_q;
  logic [CNT_W-1:0] rmn_grp_q;
  logic [CNT_W-1:0] rmn_seg_q;
  logic [CNT_W-1:0] rmn_txn_q;

  // Latched request
  logic [ADDR_W-1:0] addr_q;
  logic [BEAT_W-1:0] len_q;
  logic              is_load_q;
  logic [CNT_W-1:0]  nr_seg_q;
  logic [CNT_W-1:0]  nr_txn_q;

  logic              req_hs;
  logic              meta_hs;
  logic              last_txn;
  logic              last_seg;
  logic              last_grp;
  logic [ADDR_W-1:0] stride;

  assign req_ready_o = !busy_q;
  assign req_hs      = req_valid_i && !busy_q;
  assign meta_hs     = busy_q && meta_ready_i;

  assign last_txn = (rmn_txn_q == '0);
  assign last_seg = (rmn_seg_q == '0);
  assign last_grp = (rmn_grp_q == '0);

  // Bytes covered by one burst
  assign stride = (ADDR_W'(len_q) + ADDR_W'(1)) * ADDR_W'(BUS_BYTES);

  // ========================================
  // Remaining counters
  // ========================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      rmn_grp_q <= '0;
      rmn_seg_q <= '0;
      rmn_txn_q <= '0;
    end else if (req_hs) begin
      busy_q    <= 1'b1;
      rmn_grp_q <= req_nr_grp_i - 1'b1;
      rmn_seg_q <= req_nr_seg_i - 1'b1;
      rmn_txn_q <= req_nr_txn_i - 1'b1;
    end else if (meta_hs) begin
      if (meta_is_final_o) begin
        busy_q <= 1'b0;
      end else if (!last_txn) begin
        rmn_txn_q <= rmn_txn_q - 1'b1;
      end else begin
        // Segment done, reload the transaction count
        rmn_txn_q <= nr_txn_q - 1'b1;
        if (!last_seg) begin
          rmn_seg_q <= rmn_seg_q - 1'b1;
        end else begin
          rmn_seg_q <= nr_seg_q - 1'b1;
          rmn_grp_q <= rmn_grp_q - 1'b1;
        end
      end
    end
  end

  // Running address and request fields
  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      addr_q    <= req_addr_i;
      len_q     <= req_len_i;
      is_load_q <= req_is_load_i;
      nr_seg_q  <= req_nr_seg_i;
      nr_txn_q  <= req_nr_txn_i;
    end else if (meta_hs) begin
      addr_q <= addr_q + stride;
    end
  end

  assign meta_valid_o    = busy_q;
  assign meta_addr_o     = addr_q;
  assign meta_len_o      = len_q;
  assign meta_is_load_o  = is_load_q;
  // All three counters on their last value
  assign meta_is_final_o = last_grp && last_seg && last_txn;

endmodule

//--- rtl/vlsu_txn_ctrl.sv
// Vector load/store transaction control top level
// Sequencer feeds the control queue, which feeds the address issue stage
module vlsu_txn_ctrl import vlsu_txn_pkg::*; import axi_ax_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Request
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  logic                  req_is_load_i,
  input  logic [ADDR_W-1:0]     req_addr_i,
  input  logic [CNT_W-1:0]      req_nr_grp_i,
  input  logic [CNT_W-1:0]      req_nr_seg_i,
  input  logic [CNT_W-1:0]      req_nr_txn_i,
  input  logic [BEAT_W-1:0]     req_len_i,
  // AW
  output logic                  aw_valid_o,
  input  logic                  aw_ready_i,
  output logic [ADDR_W-1:0]     aw_addr_o,
  output logic [AX_LEN_W-1:0]   aw_len_o,
  output logic [AX_SIZE_W-1:0]  aw_size_o,
  output logic [AX_BURST_W-1:0] aw_burst_o,
  output logic [AX_CACHE_W-1:0] aw_cache_o,
  // AR
  output logic                  ar_valid_o,
  input  logic                  ar_ready_i,
  output logic [ADDR_W-1:0]     ar_addr_o,
  output logic [AX_LEN_W-1:0]   ar_len_o,
  output logic [AX_SIZE_W-1:0]  ar_size_o,
  output logic [AX_BURST_W-1:0] ar_burst_o,
  output logic [AX_CACHE_W-1:0] ar_cache_o,
  // Data side
  input  logic                  update_i,
  output logic                  txn_ctrl_valid_o,
  output logic [ADDR_W-1:0]     txn_ctrl_addr_o,
  output logic [BEAT_W-1:0]     txn_ctrl_rmn_beat_o,
  output logic                  txn_ctrl_is_head_o,
  output logic                  txn_ctrl_is_final_o,
  // B
  input  logic                  b_valid_i,
  output logic                  b_ready_o
);

  // Sequencer to queue
  logic              meta_valid;
  logic              meta_ready;
  logic [ADDR_W-1:0] meta_addr;
  logic [BEAT_W-1:0] meta_len;
  logic              meta_is_load;
  logic              meta_is_final;

  // Queue to issue stage
  logic      ax_valid;
  logic      ax_ready;
  txn_ctrl_t ax_entry;

  vlsu_meta_seq i_meta_seq (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_is_load_i   (req_is_load_i),
    .req_addr_i      (req_addr_i),
    .req_nr_grp_i    (req_nr_grp_i),
    .req_nr_seg_i    (req_nr_seg_i),
    .req_nr_txn_i    (req_nr_txn_i),
    .req_len_i       (req_len_i),
    .meta_valid_o    (meta_valid),
    .meta_ready_i    (meta_ready),
    .meta_addr_o     (meta_addr),
    .meta_len_o      (meta_len),
    .meta_is_load_o  (meta_is_load),
    .meta_is_final_o (meta_is_final)
  );

  vlsu_txn_ctrl_queue i_txn_queue (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .meta_valid_i        (meta_valid),
    .meta_ready_o        (meta_ready),
    .meta_addr_i         (meta_addr),
    .meta_len_i          (meta_len),
    .meta_is_load_i      (meta_is_load),
    .meta_is_final_i     (meta_is_final),
    .ax_valid_o          (ax_valid),
    .ax_ready_i          (ax_ready),
    .ax_entry_o          (ax_entry),
    .update_i            (update_i),
    .txn_ctrl_valid_o    (txn_ctrl_valid_o),
    .txn_ctrl_addr_o     (txn_ctrl_addr_o),
    .txn_ctrl_rmn_beat_o (txn_ctrl_rmn_beat_o),
    .txn_ctrl_is_head_o  (txn_ctrl_is_head_o),
    .txn_ctrl_is_final_o (txn_ctrl_is_final_o),
    .b_valid_i           (b_valid_i),
    .b_ready_o           (b_ready_o)
  );

  vlsu_ax_issue i_ax_issue (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ax_valid_i (ax_valid),
    .ax_ready_o (ax_ready),
    .ax_entry_i (ax_entry),
    .aw_valid_o (aw_valid_o),
    .aw_ready_i (aw_ready_i),
    .aw_addr_o  (aw_addr_o),
    .aw_len_o   (aw_len_o),
    .aw_size_o  (aw_size_o),
    .aw_burst_o (aw_burst_o),
    .aw_cache_o (aw_cache_o),
    .ar_valid_o (ar_valid_o),
    .ar_ready_i (ar_ready_i),
    .ar_addr_o  (ar_addr_o),
    .ar_len_o   (ar_len_o),
    .ar_size_o  (ar_size_o),
    .ar_burst_o (ar_burst_o),
    .ar_cache_o (ar_cache_o)
  );

endmodule

//--- rtl/vlsu_txn_ctrl_queue.sv
// Transaction control queue
// Four entries tracked by enqueue, issue, data and dequeue pointers.
// Loads retire once their beats are done, stores on a write response
module vlsu_txn_ctrl_queue import vlsu_txn_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Metadata in
  input  logic              meta_valid_i,
  output logic              meta_ready_o,
  input  logic [ADDR_W-1:0] meta_addr_i,
  input  logic [BEAT_W-1:0] meta_len_i,
  input  logic              meta_is_load_i,
  input  logic              meta_is_final_i,
  // Entry offered for address issue
  output logic              ax_valid_o,
  input  logic              ax_ready_i,
  output txn_ctrl_t         ax_entry_o,
  // Data side
  input  logic              update_i,
  output logic              txn_ctrl_valid_o,
  output logic [ADDR_W-1:0] txn_ctrl_addr_o,
  output logic [BEAT_W-1:0] txn_ctrl_rmn_beat_o,
  output logic              txn_ctrl_is_head_o,
  output logic              txn_ctrl_is_final_o,
  // Write response
  input  logic              b_valid_i,
  output logic              b_ready_o
);

  txn_ctrl_t entries_q [TXN_CTRL_NUM];

  // Pointer indices and wrap flags
  logic [TXN_PTR_W-1:0] enq_val, iss_val, data_val, deq_val;
  logic                 enq_flag, iss_flag, data_flag, deq_flag;
  // Flag and index together
  logic [TXN_PTR_W:0]   enq_ptr, iss_ptr, data_ptr, deq_ptr;

  logic      full, empty;
  logic      do_enq, do_iss, do_beat, do_data, do_deq;
  logic      data_passed;
  txn_ctrl_t new_entry;
  txn_ctrl_t data_entry;
  txn_ctrl_t deq_entry;

  assign enq_ptr  = {enq_flag, enq_val};
  assign iss_ptr  = {iss_flag, iss_val};
  assign data_ptr = {data_flag, data_val};
  assign deq_ptr  = {deq_flag, deq_val};

  // ========================================
  // Occupancy and handshakes
  // ========================================
  assign empty = (enq_ptr == deq_ptr);
  assign full  = (enq_val == deq_val) && (enq_flag != deq_flag);

  assign meta_ready_o = !full;
  assign do_enq       = meta_valid_i && !full;

  // Entry at the issue pointer not yet sent
  assign ax_valid_o = !empty && (iss_ptr != enq_ptr);
  assign ax_entry_o = entries_q[iss_val];
  assign do_iss     = ax_valid_o && ax_ready_i;

  // Data side entry
  assign data_entry       = entries_q[data_val];
  assign txn_ctrl_valid_o = (data_ptr != enq_ptr);
  assign do_beat = update_i && txn_ctrl_valid_o && (data_entry.rmn_beat != '0);
  // Last beat moves on to the next entry
  assign do_data = update_i && txn_ctrl_valid_o && (data_entry.rmn_beat == '0);

  // Retirement, oldest entry has all its beats
  assign deq_entry   = entries_q[deq_val];
  assign data_passed = (data_ptr != deq_ptr);
  assign b_ready_o   = data_passed && !deq_entry.is_load;
  assign do_deq      = data_passed && (deq_entry.is_load || b_valid_i);

  assign txn_ctrl_addr_o     = data_entry.addr;
  assign txn_ctrl_rmn_beat_o = data_entry.rmn_beat;
  assign txn_ctrl_is_head_o  = data_entry.is_head;
  assign txn_ctrl_is_final_o = data_entry.is_final;

  // ========================================
  // Entry storage
  // ========================================
  always_comb begin
    new_entry          = '0;
    new_entry.addr     = meta_addr_i;
    new_entry.rmn_beat = meta_len_i;
    new_entry.is_head  = 1'b1;
    new_entry.is_load  = meta_is_load_i;
    new_entry.is_final = meta_is_final_i;
  end

  // Enqueue and beat slots never coincide while not full
  always_ff @(posedge clk_i) begin
    if (do_enq) begin
      entries_q[enq_val] <= new_entry;
    end
    if (do_beat) begin
      entries_q[data_val].rmn_beat <= data_entry.rmn_beat - 1'b1;
      entries_q[data_val].is_head  <= 1'b0;
    end
  end

  // ========================================
  // Pointers
  // ========================================
  vlsu_circ_ptr i_enq_ptr (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .inc_i   (do_enq),
    .flag_o  (enq_flag),
    .value_o (enq_val)
  );

  vlsu_circ_ptr i_iss_ptr (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .inc_i   (do_iss),
    .flag_o  (iss_flag),
    .value_o (iss_val)
  );

  vlsu_circ_ptr i_data_ptr (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .inc_i   (do_data),
    .flag_o  (data_flag),
    .value_o (data_val)
  );

  vlsu_circ_ptr i_deq_ptr (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .inc_i   (do_deq),
    .flag_o  (deq_flag),
    .value_o (deq_val)
  );

endmodule

//--- rtl/vlsu_txn_pkg.sv
// Vector load/store transaction control definitions
// Queue geometry, request field widths and the queue entry layout
package vlsu_txn_pkg;

  // ========================================
  // Queue geometry
  // ========================================

  // Number of transaction control entries
  localparam int unsigned TXN_CTRL_NUM = 4;
  // Index width of a queue pointer
  localparam int unsigned TXN_PTR_W    = 2;

  // ========================================
  // Request fields
  // ========================================

  // Byte address width
  localparam int unsigned ADDR_W    = 32;
  // Group, segment and transaction counts
  localparam int unsigned CNT_W     = 4;
  // Beats minus one of a burst
  localparam int unsigned BEAT_W    = 8;
  // Bytes moved per data beat
  localparam int unsigned BUS_BYTES = 8;

  // ========================================
  // Queue entry
  // ========================================

  // One AXI transaction in flight, 44 bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    // Beats still to come, minus one
    logic [BEAT_W-1:0] rmn_beat;
    // No beat seen yet
    logic              is_head;
    logic              is_load;
    // Last transaction of the request
    logic              is_final;
    // Kept zero
    logic              spare;
  } txn_ctrl_t;

endpackage

//--- sim/tb_vlsu_txn_ctrl.sv
// Testbench for the vector load/store transaction control slice
// Directed tests send requests, act as AXI slave and data side,
// and compare every address request and data-side entry with a reference model
module tb_vlsu_txn_ctrl;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned TIMEOUT = 3000;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        req_valid_i, req_ready_o, req_is_load_i;
  logic [31:0] req_addr_i;
  logic [3:0]  req_nr_grp_i, req_nr_seg_i, req_nr_txn_i;
  logic [7:0]  req_len_i;
  logic        aw_valid_o, aw_ready_i, ar_valid_o, ar_ready_i;
  logic [31:0] aw_addr_o, ar_addr_o;
  logic [7:0]  aw_len_o, ar_len_o;
  logic [2:0]  aw_size_o, ar_size_o;
  logic [1:0]  aw_burst_o, ar_burst_o;
  logic [3:0]  aw_cache_o, ar_cache_o;
  logic        update_i, txn_ctrl_valid_o, txn_ctrl_is_head_o, txn_ctrl_is_final_o;
  logic [31:0] txn_ctrl_addr_o;
  logic [7:0]  txn_ctrl_rmn_beat_o;
  logic        b_valid_i, b_ready_o;

  // Reference model state for the current request
  logic [31:0] exp_addr_q[$];
  logic        exp_load;
  logic [7:0]  exp_len;

  string       cur_test;
  int unsigned err_cnt, test_err_base, tests_ok, tests_bad;

  vlsu_txn_ctrl i_dut (.*);

  // 4 ns period
  always #2 clk_i = ~clk_i;

  // ========================================
  // Helpers
  // ========================================
  task automatic check_value(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
    if (exp !== act) begin
      $display("Error: %s %s expected %0h actual %0h", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #0.5;
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = err_cnt;
  endtask

  task automatic finish_test();
    if (err_cnt == test_err_base) begin
      $display("%s: ok", cur_test);
      tests_ok++;
    end else begin
      $display("%s: %0d errors", cur_test, err_cnt - test_err_base);
      tests_bad++;
    end
  endtask

  // Reset held for 3 cycles with all inputs idle
  task automatic apply_reset();
    rst_ni        = 1'b0;
    req_valid_i   = 1'b0;
    req_is_load_i = 1'b0;
    req_addr_i    = '0;
    req_nr_grp_i  = '0;
    req_nr_seg_i  = '0;
    req_nr_txn_i  = '0;
    req_len_i     = '0;
    aw_ready_i    = 1'b0;
    ar_ready_i    = 1'b0;
    update_i      = 1'b0;
    b_valid_i     = 1'b0;
    repeat (3) @(posedge clk_i);
    #0.5;
    rst_ni = 1'b1;
  endtask

  task automatic check_idle();
    check_value("aw_valid_o idle", 0, aw_valid_o);
    check_value("ar_valid_o idle", 0, ar_valid_o);
    check_value("txn_ctrl_valid_o idle", 0, txn_ctrl_valid_o);
    check_value("b_ready_o idle", 0, b_ready_o);
    check_value("req_ready_o idle", 1, req_ready_o);
  endtask

  // Transaction k sits at base + k * (len + 1) * 8
  // Ordered by group, then segment, then transaction
  task automatic build_expected(input logic is_load, input logic [31:0] base,
                                input int unsigned grp, input int unsigned seg,
                                input int unsigned txn, input logic [7:0] len);
    int unsigned k;
    exp_addr_q.delete();
    exp_load = is_load;
    exp_len  = len;
    k        = 0;
    for (int unsigned g = 0; g < grp; g++) begin
      for (int unsigned s = 0; s < seg; s++) begin
        for (int unsigned t = 0; t < txn; t++) begin
          exp_addr_q.push_back(base + 32'(k) * (32'(len) + 32'd1) * 32'd8);
          k++;
        end
      end
    end
  endtask

  // Returns one cycle after the request handshake
  task automatic send_request(input logic is_load, input logic [31:0] base,
                              input int unsigned grp, input int unsigned seg,
                              input int unsigned txn, input logic [7:0] len);
    int unsigned waited;
    build_expected(is_load, base, grp, seg, txn, len);
    waited = 0;
    while (!req_ready_o && waited < TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (!req_ready_o) begin
      $display("%s: request never accepted, req_ready_o stayed low", cur_test);
      err_cnt++;
    end else begin
      req_is_load_i = is_load;
      req_addr_i    = base;
      req_nr_grp_i  = 4'(grp);
      req_nr_seg_i  = 4'(seg);
      req_nr_txn_i  = 4'(txn);
      req_len_i     = len;
      req_valid_i   = 1'b1;
      next_cycle();
      req_valid_i   = 1'b0;
    end
  endtask

  // ========================================
  // Slave model
  // ========================================
  // Ready gaps occur with a chance of gap_pct percent
  // Address ready stays low for the first hold cycles
  // A B response waits b_hold cycles once the store data is done
  task automatic serve_slave(input int unsigned gap_pct, input int unsigned hold,
                             input int unsigned b_hold, output int unsigned first_ax);
    int unsigned cyc, n, acc_cnt, data_cnt, data_done, beat_idx, b_cnt, b_wait;
    logic        ax_valid, prev_stall, rdy;
    logic [31:0] ax_addr, prev_addr;
    n          = exp_addr_q.size();
    cyc        = 1;
    acc_cnt    = 0;
    data_cnt   = 0;
    beat_idx   = 0;
    b_cnt      = 0;
    b_wait     = 0;
    first_ax   = 0;
    prev_stall = 1'b0;
    prev_addr  = '0;
    while ((exp_load ? data_cnt : b_cnt) < n && cyc <= TIMEOUT) begin
      data_done = data_cnt;
      check_value("AW and AR valid together", 0, aw_valid_o && ar_valid_o);
      if (exp_load) begin
        check_value("AW valid on a load", 0, aw_valid_o);
      end else begin
        check_value("AR valid on a store", 0, ar_valid_o);
      end
      ax_valid = exp_load ? ar_valid_o : aw_valid_o;
      ax_addr  = exp_load ? ar_addr_o : aw_addr_o;
      // Request must hold while stalled
      if (prev_stall) begin
        check_value("valid dropped under back-pressure", 1, ax_valid);
        check_value("address changed under back-pressure", prev_addr, ax_addr);
      end
      if (ax_valid && first_ax == 0) begin
        first_ax = cyc;
      end
      if (cyc <= hold) begin
        check_value("req_ready_o while request pending", 0, req_ready_o);
      end
      if (cyc == hold) begin
        check_value("meta accepted while queue full", 0, i_dut.meta_ready);
      end

      // Beats only for transactions whose address was accepted
      update_i = 1'b0;
      if (data_cnt < acc_cnt && $urandom_range(99) >= gap_pct) begin
        check_value("txn_ctrl_valid_o", 1, txn_ctrl_valid_o);
        check_value("txn_ctrl_addr_o", exp_addr_q[data_cnt], txn_ctrl_addr_o);
        check_value("txn_ctrl_rmn_beat_o", exp_len - beat_idx, txn_ctrl_rmn_beat_o);
        check_value("txn_ctrl_is_head_o", beat_idx == 0, txn_ctrl_is_head_o);
        check_value("txn_ctrl_is_final_o", data_cnt == n - 1, txn_ctrl_is_final_o);
        update_i = 1'b1;
        if (beat_idx == exp_len) begin
          beat_idx = 0;
          data_cnt++;
        end else begin
          beat_idx++;
        end
      end

      // Write response once the store data is done
      b_valid_i = 1'b0;
      if (!exp_load && b_cnt < data_done) begin
        check_value("b_ready_o before B", 1, b_ready_o);
        if (b_wait >= b_hold && $urandom_range(99) >= gap_pct) begin
          b_valid_i = 1'b1;
          b_cnt++;
          b_wait = 0;
        end else begin
          b_wait++;
        end
      end

      rdy        = (cyc > hold) && ($urandom_range(99) >= gap_pct);
      aw_ready_i = rdy;
      ar_ready_i = rdy;
      if (ax_valid && rdy) begin
        if (acc_cnt < n) begin
          check_value("address", exp_addr_q[acc_cnt], ax_addr);
          check_value("len", exp_len, exp_load ? ar_len_o : aw_len_o);
          check_value("size", 3'd3, exp_load ? ar_size_o : aw_size_o);
          check_value("burst", 2'b01, exp_load ? ar_burst_o : aw_burst_o);
          check_value("cache", 4'b0010, exp_load ? ar_cache_o : aw_cache_o);
        end else begin
          $display("%s: address request beyond the last transaction", cur_test);
          err_cnt++;
        end
        acc_cnt++;
      end
      prev_stall = ax_valid && !rdy;
      prev_addr  = ax_addr;
      next_cycle();
      cyc++;
    end
    aw_ready_i = 1'b0;
    ar_ready_i = 1'b0;
    update_i   = 1'b0;
    b_valid_i  = 1'b0;
    if ((exp_load ? data_cnt : b_cnt) < n) begin
      $display("%s: timed out after %0d cycles, only %0d of %0d transactions done",
               cur_test, cyc, exp_load ? data_cnt : b_cnt, n);
      err_cnt++;
    end
  endtask

  // ========================================
  // Directed tests
  // ========================================
  task automatic reset_state();
    start_test("reset");
    apply_reset();
    check_idle();
    finish_test();
  endtask

  task automatic single_load();
    int unsigned first_ax;
    start_test("single_load");
    apply_reset();
    send_request(1'b1, 32'h0000_2000, 1, 1, 1, 8'd3);
    serve_slave(0, 0, 0, first_ax);
    // Meta, enqueue, issue register
    check_value("cycles to first AR", 3, first_ax);
    next_cycle();
    check_idle();
    finish_test();
  endtask

  task automatic single_store();
    int unsigned first_ax;
    start_test("single_store");
    apply_reset();
    send_request(1'b0, 32'h0001_0040, 1, 1, 1, 8'd1);
    serve_slave(0, 0, 5, first_ax);
    check_value("cycles to first AW", 3, first_ax);
    next_cycle();
    check_idle();
    finish_test();
  endtask

  task automatic multi_dim_request();
    int unsigned first_ax;
    start_test("multi_dim");
    apply_reset();
    send_request(1'b1, 32'h8000_1000, 2, 2, 3, 8'd1);
    serve_slave(20, 0, 0, first_ax);
    next_cycle();
    check_idle();
    finish_test();
  endtask

  task automatic back_pressure();
    int unsigned first_ax;
    start_test("back_pressure");
    apply_reset();
    send_request(1'b1, 32'h0004_0000, 1, 3, 4, 8'd3);
    serve_slave(0, 20, 0, first_ax);
    next_cycle();
    check_idle();
    finish_test();
  endtask

  task automatic random_requests();
    int unsigned first_ax;
    start_test("random_mix");
    apply_reset();
    for (int unsigned i = 0; i < 8; i++) begin
      send_request(1'($urandom_range(1)), $urandom & 32'hFFFF_FFF8,
                   $urandom_range(3, 1), $urandom_range(2, 1), $urandom_range(3, 1),
                   8'($urandom_range(7)));
      serve_slave($urandom_range(50), 0, $urandom_range(3), first_ax);
      next_cycle();
      check_idle();
    end
    finish_test();
  endtask

  initial begin
    void'($urandom(32'h7c7b7a1d));
    err_cnt   = 0;
    tests_ok  = 0;
    tests_bad = 0;
    apply_reset();
    reset_state();
    single_load();
    single_store();
    multi_dim_request();
    back_pressure();
    random_requests();
    $display("Tests: %0d ok, %0d failing, %0d errors", tests_ok, tests_bad, err_cnt);
    if (tests_bad == 0 && err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- vlsu_txn_ctrl.f
rtl/vlsu_txn_pkg.sv
rtl/axi_ax_pkg.sv
rtl/vlsu_circ_ptr.sv
rtl/vlsu_meta_seq.sv
rtl/vlsu_txn_ctrl_queue.sv
rtl/vlsu_ax_issue.sv
rtl/vlsu_txn_ctrl.sv
sim/tb_vlsu_txn_ctrl.sv
